// File: hw/memPkg.sv
// Shared geometry of the on-chip memory subsystem
// Word, column and address widths used by every block

package memPkg;

   localparam int addrW  = 10;               // Word address, 1024 words
   localparam int depth  = 2 ** addrW;
   localparam int dataW  = 32;
   localparam int colW   = 8;                // One byte column

   // Byte columns per word, also the width of each write-enable vector
   localparam int numCol = dataW / colW;

   // Copy length needs one extra bit so a full-memory copy fits
   localparam int lenW   = addrW + 1;

endpackage

// File: hw/tdpRamBe.sv
// True dual-port RAM with byte write enables, read-first on both ports
// Both ports share clkA; each output register holds while its port is idle

`timescale 1ns/10ps

module tdpRamBe (
   input  logic                       clkA,
   // Port A
   input  logic                       enA,
   input  logic [memPkg::numCol-1:0]  weA,
   input  logic [memPkg::addrW-1:0]   addrA,
   input  logic [memPkg::dataW-1:0]   dinA,
   output logic [memPkg::dataW-1:0]   doutA,
   // Port B
   input  logic                       enB,
   input  logic [memPkg::numCol-1:0]  weB,
   input  logic [memPkg::addrW-1:0]   addrB,
   input  logic [memPkg::dataW-1:0]   dinB,
   output logic [memPkg::dataW-1:0]   doutB
);

   logic [memPkg::dataW-1:0] memArray [memPkg::depth];

   logic [memPkg::dataW-1:0] doutAQ;
   logic [memPkg::dataW-1:0] doutBQ;

   // Same address on both ports in one cycle is undefined
   always_ff @(posedge clkA) begin
      if (enA) begin
         for (int i = 0; i < memPkg::numCol; i++) begin
            if (weA[i]) begin
               memArray[addrA][i*memPkg::colW +: memPkg::colW] <=
                  dinA[i*memPkg::colW +: memPkg::colW];
            end
         end
         doutAQ <= memArray[addrA];     // Old word, read-first
      end

      if (enB) begin
         for (int j = 0; j < memPkg::numCol; j++) begin
            if (weB[j]) begin
               memArray[addrB][j*memPkg::colW +: memPkg::colW] <=
                  dinB[j*memPkg::colW +: memPkg::colW];
            end
         end
         doutBQ <= memArray[addrB];     // Old word, read-first
      end
   end

   assign doutA = doutAQ;
   assign doutB = doutBQ;

endmodule

// File: hw/hostPort.sv
// Host access path onto RAM port A
// Gates byte strobes with the request and flags returned read data

`timescale 1ns/10ps

module hostPort (
   input  logic                       clkA,
   input  logic                       arstN,
   // Host side
   input  logic                       hostReq,
   input  logic [memPkg::numCol-1:0]  hostWe,
   input  logic [memPkg::addrW-1:0]   hostAddr,
   input  logic [memPkg::dataW-1:0]   hostWdata,
   output logic                       hostRvalid,
   output logic [memPkg::dataW-1:0]   hostRdata,
   // RAM port A
   output logic                       ramEnA,
   output logic [memPkg::numCol-1:0]  ramWeA,
   output logic [memPkg::addrW-1:0]   ramAddrA,
   output logic [memPkg::dataW-1:0]   ramDinA,
   input  logic [memPkg::dataW-1:0]   ramDoutA
);

   logic isRead;
   logic rdPend;

   assign isRead   = hostReq && (hostWe == '0);

   assign ramEnA   = hostReq;
   assign ramWeA   = hostReq ? hostWe : '0;   // No stray writes when idle
   assign ramAddrA = hostAddr;
   assign ramDinA  = hostWdata;

   // One read per cycle may be in flight, so a single flag is enough
   always_ff @(posedge clkA or negedge arstN) begin
      if (!arstN) begin
         rdPend <= 1'b0;
      end else begin
         rdPend <= isRead;
      end
   end

   assign hostRvalid = rdPend;
   assign hostRdata  = ramDoutA;      // Port A register holds the read word

endmodule

// File: hw/copyEngine.sv
// Block copy FSM on RAM port B
// Alternates a read and a write per word and drives the checksum strobes

`timescale 1ns/10ps

module copyEngine (
   input  logic                       clkA,
   input  logic                       arstN,
   input  logic                       copyStart,
   input  logic [memPkg::addrW-1:0]   copySrc,
   input  logic [memPkg::addrW-1:0]   copyDst,
   input  logic [memPkg::lenW-1:0]    copyLen,
   output logic                       copyBusy,
   output logic                       copyDone,
   // RAM port B control
   output logic                       ramEnB,
   output logic [memPkg::numCol-1:0]  ramWeB,
   output logic [memPkg::addrW-1:0]   ramAddrB,
   // Checksum strobes
   output logic                       sumClear,
   output logic                       sumAdd
);

   typedef enum logic [1:0] {
      stIdle,
      stRead,
      stWrite,
      stFinish
   } copyState_t;

   copyState_t state;

   logic [memPkg::addrW-1:0] srcQ;
   logic [memPkg::addrW-1:0] dstQ;
   logic [memPkg::lenW-1:0]  remainQ;
   logic                     startOk;

   assign copyBusy = (state == stRead) || (state == stWrite);
   assign copyDone = (state == stFinish);

   // Start is dropped while a copy is running
   assign startOk  = copyStart && !copyBusy;
   assign sumClear = startOk;

   always_ff @(posedge clkA or negedge arstN) begin
      if (!arstN) begin
         state   <= stIdle;
         srcQ    <= '0;
         dstQ    <= '0;
         remainQ <= '0;
      end else begin
         case (state)
            stIdle, stFinish: begin
               if (startOk) begin
                  srcQ    <= copySrc;
                  dstQ    <= copyDst;
                  remainQ <= copyLen;
                  // Zero length goes straight to the done pulse
                  state   <= (copyLen == '0) ? stFinish : stRead;
               end else begin
                  state   <= stIdle;
               end
            end
            stRead: begin
               state <= stWrite;
            end
            stWrite: begin
               srcQ    <= srcQ + 1'b1;
               dstQ    <= dstQ + 1'b1;
               remainQ <= remainQ - 1'b1;
               if (remainQ == memPkg::lenW'(1)) begin
                  state <= stFinish;       // Last word written
               end else begin
                  state <= stRead;
               end
            end
            default: begin
               state <= stIdle;
            end
         endcase
      end
   end

   // Port B: read from source, then write that word back to destination
   always_comb begin
      ramEnB   = copyBusy;
      ramWeB   = '0;
      ramAddrB = srcQ;
      sumAdd   = 1'b0;
      if (state == stWrite) begin
         ramWeB   = '1;
         ramAddrB = dstQ;
         sumAdd   = 1'b1;   // RAM output holds the word being written
      end
   end

endmodule

// File: hw/wordChecksum.sv
// Modular 32-bit sum of the words moved by the copy engine
// Holds its value between copies so the last result stays readable

`timescale 1ns/10ps

module wordChecksum (
   input  logic                       clkA,
   input  logic                       arstN,
   input  logic                       sumClear,
   input  logic                       sumAdd,
   input  logic [memPkg::dataW-1:0]   word,
   output logic [memPkg::dataW-1:0]   sum
);

   logic [memPkg::dataW-1:0] accQ;

   always_ff @(posedge clkA or negedge arstN) begin
      if (!arstN) begin
         accQ <= '0;
      end else if (sumClear) begin
         accQ <= '0;               // New copy starts from zero
      end else if (sumAdd) begin
         accQ <= accQ + word;      // Carry out dropped, wraps mod 2^32
      end
   end

   assign sum = accQ;

endmodule

// File: hw/memSubsys.sv
// Shared memory subsystem top level
// Host on RAM port A, block copy engine with checksum on port B

`timescale 1ns/10ps

module memSubsys (
   input  logic                       clkA,
   input  logic                       arstN,
   // Host side
   input  logic                       hostReq,
   input  logic [memPkg::numCol-1:0]  hostWe,
   input  logic [memPkg::addrW-1:0]   hostAddr,
   input  logic [memPkg::dataW-1:0]   hostWdata,
   output logic                       hostRvalid,
   output logic [memPkg::dataW-1:0]   hostRdata,
   // Copy side
   input  logic                       copyStart,
   input  logic [memPkg::addrW-1:0]   copySrc,
   input  logic [memPkg::addrW-1:0]   copyDst,
   input  logic [memPkg::lenW-1:0]    copyLen,
   output logic                       copyBusy,
   output logic                       copyDone,
   output logic [memPkg::dataW-1:0]   copySum
);

   // Port A
   logic                      ramEnA;
   logic [memPkg::numCol-1:0] ramWeA;
   logic [memPkg::addrW-1:0]  ramAddrA;
   logic [memPkg::dataW-1:0]  ramDinA;
   logic [memPkg::dataW-1:0]  ramDoutA;

   // Port B
   logic                      ramEnB;
   logic [memPkg::numCol-1:0] ramWeB;
   logic [memPkg::addrW-1:0]  ramAddrB;
   logic [memPkg::dataW-1:0]  ramDoutB;

   logic                      sumClear;
   logic                      sumAdd;

   hostPort uHostPort (
      .clkA       (clkA),
      .arstN      (arstN),
      .hostReq    (hostReq),
      .hostWe     (hostWe),
      .hostAddr   (hostAddr),
      .hostWdata  (hostWdata),
      .hostRvalid (hostRvalid),
      .hostRdata  (hostRdata),
      .ramEnA     (ramEnA),
      .ramWeA     (ramWeA),
      .ramAddrA   (ramAddrA),
      .ramDinA    (ramDinA),
      .ramDoutA   (ramDoutA)
   );

   copyEngine uCopyEngine (
      .clkA      (clkA),
      .arstN     (arstN),
      .copyStart (copyStart),
      .copySrc   (copySrc),
      .copyDst   (copyDst),
      .copyLen   (copyLen),
      .copyBusy  (copyBusy),
      .copyDone  (copyDone),
      .ramEnB    (ramEnB),
      .ramWeB    (ramWeB),
      .ramAddrB  (ramAddrB),
      .sumClear  (sumClear),
      .sumAdd    (sumAdd)
   );

   // Read data loops straight back as write data on port B
   tdpRamBe uRam (
      .clkA  (clkA),
      .enA   (ramEnA),
      .weA   (ramWeA),
      .addrA (ramAddrA),
      .dinA  (ramDinA),
      .doutA (ramDoutA),
      .enB   (ramEnB),
      .weB   (ramWeB),
      .addrB (ramAddrB),
      .dinB  (ramDoutB),
      .doutB (ramDoutB)
   );

   wordChecksum uChecksum (
      .clkA     (clkA),
      .arstN    (arstN),
      .sumClear (sumClear),
      .sumAdd   (sumAdd),
      .word     (ramDoutB),       // Same word that is being written
      .sum      (copySum)
   );

endmodule

// File: verif/memSubsysTb.sv
// Self-checking testbench for the shared memory subsystem
// Shadow memory model with host traffic, block copies and checksum checks

`timescale 1ns/10ps

module memSubsysTb;

   logic                       clkA;
   logic                       arstN;
   logic                       hostReq;
   logic [memPkg::numCol-1:0]  hostWe;
   logic [memPkg::addrW-1:0]   hostAddr;
   logic [memPkg::dataW-1:0]   hostWdata;
   logic                       hostRvalid;
   logic [memPkg::dataW-1:0]   hostRdata;
   logic                       copyStart;
   logic [memPkg::addrW-1:0]   copySrc;
   logic [memPkg::addrW-1:0]   copyDst;
   logic [memPkg::lenW-1:0]    copyLen;
   logic                       copyBusy;
   logic                       copyDone;
   logic [memPkg::dataW-1:0]   copySum;

   logic [memPkg::dataW-1:0]   shadow [memPkg::depth];   // Expected RAM contents
   logic [15:0]                lfsrState;
   logic [memPkg::dataW-1:0]   expSum;
   logic [memPkg::dataW-1:0]   pendData;
   logic                       pendRead;
   logic                       copyActive;
   logic                       doneSeen;
   int                         copyCycle;
   int                         copyLast;
   int                         errCount;

   memSubsys uut (.*);

   always #5 clkA = ~clkA;

   // 16-bit Fibonacci LFSR stepped once per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
         lfsrState = {lfsrState[14:0], fb};
         val       = {val[30:0], fb};
      end
      return val;
   endfunction

   task automatic valueMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
      errCount++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, expVal, actVal);
   endtask

   task automatic failNote(input string msg);
      errCount++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   // Waits one edge, notes copyDone there, then moves to the drive point
   task automatic tick();
      @(posedge clkA);
      doneSeen = copyDone;
      #1;
   endtask

   task automatic hostAccess(input logic [memPkg::addrW-1:0] addr,
                             input logic [memPkg::numCol-1:0] we,
                             input logic [memPkg::dataW-1:0] data);
      hostReq   = 1'b1;
      hostWe    = we;
      hostAddr  = addr;
      hostWdata = data;
      for (int i = 0; i < memPkg::numCol; i++) begin
         if (we[i]) shadow[addr][i*memPkg::colW +: memPkg::colW] =
            data[i*memPkg::colW +: memPkg::colW];
      end
      tick();
   endtask

   task automatic hostIdle();
      hostReq = 1'b0;
      hostWe  = '0;
   endtask

   // Copy with host traffic in words 0..63 while it runs
   task automatic runCopy(input int src, input int dst, input int len);
      logic [31:0] sum;
      int          cyc;
      int          limit;
      sum = '0;
      for (int k = 0; k < len; k++) begin   // Ascending order word by word
         sum             = sum + shadow[src+k];
         shadow[dst+k]   = shadow[src+k];
      end
      expSum    = sum;
      copySrc   = src;
      copyDst   = dst;
      copyLen   = len;
      copyStart = 1'b1;
      tick();
      limit    = 2 * len + 8;
      doneSeen = 1'b0;
      for (cyc = 0; cyc < limit && !doneSeen; cyc++) begin
         copyStart = (cyc == 1) && (len > 1);   // Start while busy is ignored
         copySrc   = src + 5;
         copyLen   = 3;
         hostAccess(randBits(6), randBits(4), randBits(32));
      end
      copyStart = 1'b0;
      hostIdle();
      if (!doneSeen) failNote("timeout waiting for copyDone");
   endtask

   task automatic readRange(input int base, input int count);
      for (int a = base; a < base + count; a++) hostAccess(a, '0, '0);
      hostIdle();
      tick();
   endtask

   // Read pipeline and copy timing checks at the rising edge
   always @(posedge clkA) begin
      if (arstN) begin
         assert (hostRvalid == pendRead) else valueMismatch("hostRvalid", pendRead, hostRvalid);
         if (pendRead) begin
            assert (hostRdata == pendData) else valueMismatch("hostRdata", pendData, hostRdata);
         end
         pendRead = hostReq && (hostWe == '0);
         pendData = shadow[hostAddr];          // Word before any write this cycle
         if (copyActive) begin
            copyCycle++;
            if (copyCycle == copyLast) begin
               assert (copyDone && !copyBusy) else failNote("copyDone missing at end of copy");
               assert (copySum == expSum) else valueMismatch("copySum", expSum, copySum);
               copyActive = 1'b0;
            end else begin
               assert (copyBusy && !copyDone) else failNote("copyBusy low or early copyDone");
            end
         end else begin
            assert (!copyBusy && !copyDone) else failNote("copy activity without a start");
         end
         if (copyStart && !copyActive) begin
            copyActive = 1'b1;
            copyCycle  = 0;
            copyLast   = (copyLen == '0) ? 1 : 2 * int'(copyLen) + 1;
         end
      end
   end

   assert property (@(posedge clkA) disable iff (!arstN) $fell(copyBusy) |-> copyDone)
      else failNote("copyBusy fell without a copyDone pulse");

   initial begin
      clkA       = 1'b0;
      arstN      = 1'b0;
      hostReq    = 1'b0;
      hostWe     = '0;
      hostAddr   = '0;
      hostWdata  = '0;
      copyStart  = 1'b0;
      copySrc    = '0;
      copyDst    = '0;
      copyLen    = '0;
      lfsrState  = 16'd27101;
      pendRead   = 1'b0;
      pendData   = '0;
      copyActive = 1'b0;
      doneSeen   = 1'b0;
      copyCycle  = 0;
      copyLast   = 0;
      expSum     = '0;
      errCount   = 0;
      repeat (2) @(posedge clkA);
      #1 arstN = 1'b1;

      assert (!hostRvalid && !copyBusy && !copyDone) else failNote("outputs active after reset");
      assert (copySum == '0) else valueMismatch("copySum", '0, copySum);

      for (int a = 0; a < memPkg::depth; a++) hostAccess(a, '1, randBits(32));

      for (int n = 0; n < 48; n++) hostAccess(randBits(6), randBits(4), randBits(32));
      readRange(0, 64);                         // Back-to-back reads

      // Read then write the same word and expect the old word back
      for (int n = 0; n < 4; n++) begin
         hostAddr = randBits(6);
         hostAccess(hostAddr, '0, '0);
         hostAccess(hostAddr, randBits(4) | 4'b0001, randBits(32));
         hostAccess(hostAddr, '0, '0);
      end
      hostIdle();

      for (int n = 0; n < 3; n++) begin
         int srcBase;
         int dstBase;
         int wordCount;
         srcBase   = 256 + randBits(7);
         dstBase   = 640 + randBits(7);
         wordCount = 1 + randBits(5);
         runCopy(srcBase, dstBase, wordCount);
         readRange(dstBase, wordCount);
      end
      runCopy(100, 900, 0);                     // Zero length
      repeat (3) tick();

      $display("Checks done, %0d errors", errCount);
      if (errCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: sim.f
hw/memPkg.sv
hw/tdpRamBe.sv
hw/hostPort.sv
hw/copyEngine.sv
hw/wordChecksum.sv
hw/memSubsys.sv
verif/memSubsysTb.sv

// File: Bender.yml
package:
  name: memSubsys

sources:
  - hw/memPkg.sv
  - hw/tdpRamBe.sv
  - hw/hostPort.sv
  - hw/copyEngine.sv
  - hw/wordChecksum.sv
  - hw/memSubsys.sv
  - target: simulation
    files:
      - verif/memSubsysTb.sv
